// ==== Bender.yml ====
package:
  name: load_unit

sources:
  - src/load_pkg.sv
  - src/ldbuf_if.sv
  - src/load_buffer.sv
  - src/load_ctrl.sv
  - src/load_result_align.sv
  - src/load_unit_top.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/tb_load_unit.sv

// ==== load_unit.f ====
+incdir+tb
src/load_pkg.sv
src/ldbuf_if.sv
src/load_buffer.sv
src/load_ctrl.sv
src/load_result_align.sv
src/load_unit_top.sv
tb/tb_load_unit.sv

// ==== src/ldbuf_if.sv ====
// signals between the load request FSM, the outstanding load table
// and the response aligner
`timescale 1ns/1ps

interface ldbuf_if import load_pkg::*; ();

  // write side, one strobe per granted request
  logic                  w;
  logic [TRANS_ID_W-1:0] wtrans_id;
  logic [ALIGN_W-1:0]    woffset;
  logic [OP_W-1:0]       wop;
  // kill issued this cycle against the last written slot
  logic                  last_kill;

  // table status
  logic                  full;
  logic [LDBUF_ID_W-1:0] windex;

  // read side, indexed by the response id
  logic                  rd_valid;
  logic [OP_W-1:0]       rop;
  logic [ALIGN_W-1:0]    roffset;
  logic [TRANS_ID_W-1:0] rtrans_id;

  // request FSM
  modport ctrl (output w, wtrans_id, woffset, wop, last_kill,
                input  full, windex);

  // load table
  modport buffer (input  w, wtrans_id, woffset, wop, last_kill,
                  output full, windex, rd_valid, rop, roffset, rtrans_id);

  // result aligner only looks at the read side
  modport align (input rd_valid, rop, roffset, rtrans_id);

endinterface

// ==== src/load_buffer.sv ====
// table of outstanding loads indexed by request id
// valid and flushed flags per slot, lowest free slot selection
`timescale 1ns/1ps

module load_buffer import load_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  flush_i,
  input  logic                  drvalid_i,
  input  logic [LDBUF_ID_W-1:0] drid_i,
  ldbuf_if.buffer               lb
);

  // slot state
  logic [NR_LDBUF-1:0] valid_q, valid_d;
  logic [NR_LDBUF-1:0] flushed_q, flushed_d;
  logic [LDBUF_ID_W-1:0] last_id_q;

  // slot payload, one array per field
  logic [TRANS_ID_W-1:0] trans_id_q [NR_LDBUF];
  logic [ALIGN_W-1:0]    offset_q   [NR_LDBUF];
  logic [OP_W-1:0]       op_q       [NR_LDBUF];

  // ------------------------------------------------------------
  // free slot
  // ------------------------------------------------------------
  assign lb.full = &valid_q;

  // scan from the top so the lowest free slot wins
  always_comb begin
    lb.windex = '0;
    for (int i = NR_LDBUF - 1; i >= 0; i--) begin
      if (!valid_q[i]) begin
        lb.windex = LDBUF_ID_W'(i);
      end
    end
  end

  // ------------------------------------------------------------
  // flag update
  // ------------------------------------------------------------
  always_comb begin
    valid_d   = valid_q;
    flushed_d = flushed_q;
    // everything in flight is stale after a flush
    if (flush_i) begin
      flushed_d = '1;
    end
    // response retires its slot
    if (drvalid_i) begin
      valid_d[drid_i] = 1'b0;
    end
    // new load takes the free slot, fresh and not flushed
    if (lb.w) begin
      valid_d[lb.windex]   = 1'b1;
      flushed_d[lb.windex] = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q   <= '0;
      flushed_q <= '0;
      last_id_q <= '0;
    end else begin
      valid_q   <= valid_d;
      flushed_q <= flushed_d;
      if (lb.w) begin
        last_id_q <= lb.windex;
      end
    end
  end

  // payload only changes on a write
  always_ff @(posedge clk_i) begin
    if (lb.w) begin
      trans_id_q[lb.windex] <= lb.wtrans_id;
      offset_q[lb.windex]   <= lb.woffset;
      op_q[lb.windex]       <= lb.wop;
    end
  end

  // ------------------------------------------------------------
  // read side
  // ------------------------------------------------------------
  assign lb.rop       = op_q[drid_i];
  assign lb.roffset   = offset_q[drid_i];
  assign lb.rtrans_id = trans_id_q[drid_i];

  // live and not flushed, and not the slot being killed right now
  assign lb.rd_valid = drvalid_i && valid_q[drid_i] && !flushed_q[drid_i] &&
                       !(lb.last_kill && (last_id_q == drid_i));

endmodule

// ==== src/load_ctrl.sv ====
// request FSM towards the data cache
// grant wait, tag cycle, kill on flush and pop towards the issue queue
`timescale 1ns/1ps

module load_ctrl import load_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  flush_i,
  // issue side
  input  logic                  valid_i,
  input  logic [ADDR_W-1:0]     vaddr_i,
  input  logic [OP_W-1:0]       op_i,
  input  logic [XLEN_BYTES-1:0] be_i,
  input  logic [TRANS_ID_W-1:0] trans_id_i,
  input  logic                  page_offset_matches_i,
  // cache grant
  input  logic                  dgnt_i,
  ldbuf_if.ctrl                 lb,
  output logic                  pop_ld_o,
  // cache request
  output logic                  dreq_o,
  output logic [TAG_W-1:0]      dtag_o,
  output logic                  dtag_valid_o,
  output logic                  dkill_o,
  output logic [XLEN_BYTES-1:0] dbe_o,
  output logic [SIZE_W-1:0]     dsize_o
);

  logic [ST_W-1:0]  state_q, state_d;
  logic [TAG_W-1:0] tag_q;
  logic             accept;
  logic             req_gnt;

  // log2 of the bytes moved by an operation
  function automatic logic [SIZE_W-1:0] op_size(input logic [OP_W-1:0] op);
    logic [SIZE_W-1:0] size;
    case (op)
      OP_LW, OP_LWU: size = 2'd2;
      OP_LH, OP_LHU: size = 2'd1;
      OP_LB, OP_LBU: size = 2'd0;
      default:       size = 2'd3;
    endcase
    return size;
  endfunction

  // new load only when a slot is free
  assign accept  = valid_i && !lb.full;
  assign req_gnt = dreq_o && dgnt_i;

  // these follow the issue queue head directly
  assign dbe_o   = be_i;
  assign dsize_o = op_size(op_i);

  // ------------------------------------------------------------
  // request FSM
  // ------------------------------------------------------------
  always_comb begin
    state_d      = state_q;
    dreq_o       = 1'b0;
    dtag_valid_o = 1'b0;
    dkill_o      = 1'b0;
    pop_ld_o     = 1'b0;

    case (state_q)
      ST_IDLE, ST_SEND_TAG: begin
        // tag of the previous grant goes out now
        if (state_q == ST_SEND_TAG) begin
          dtag_valid_o = 1'b1;
          state_d      = ST_IDLE;
        end
        if (accept) begin
          if (page_offset_matches_i) begin
            // store to the same offset still pending
            state_d = ST_WAIT_PAGE_OFFSET;
          end else begin
            dreq_o = 1'b1;
            if (dgnt_i) begin
              pop_ld_o = 1'b1;
              state_d  = ST_SEND_TAG;
            end else begin
              state_d = ST_WAIT_GNT;
            end
          end
        end
      end

      // hold the request until the cache takes it
      ST_WAIT_GNT: begin
        dreq_o = 1'b1;
        if (dgnt_i) begin
          pop_ld_o = 1'b1;
          state_d  = ST_SEND_TAG;
        end
      end

      // no request while the offset still matches
      ST_WAIT_PAGE_OFFSET: begin
        if (!page_offset_matches_i) begin
          state_d = ST_WAIT_GNT;
        end
      end

      // kill whatever tag the cache is expecting
      ST_WAIT_FLUSH: begin
        dkill_o      = 1'b1;
        dtag_valid_o = 1'b1;
        state_d      = ST_IDLE;
      end

      default: begin
        state_d = ST_IDLE;
      end
    endcase

    // flush wins over any other transition
    if (flush_i) begin
      state_d = ST_WAIT_FLUSH;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // tag is sampled at grant and shown in the following cycle
  always_ff @(posedge clk_i) begin
    if (req_gnt) begin
      tag_q <= vaddr_i[INDEX_W +: TAG_W];
    end
  end

  assign dtag_o = tag_q;

  // ------------------------------------------------------------
  // load table write
  // ------------------------------------------------------------
  assign lb.w         = req_gnt;
  assign lb.wtrans_id = trans_id_i;
  assign lb.woffset   = vaddr_i[ALIGN_W-1:0];
  assign lb.wop       = op_i;
  assign lb.last_kill = dkill_o;

endmodule

// ==== src/load_pkg.sv ====
// shared widths, load operation codes and FSM state codes of the load unit
// plus the union used to read a cache response word as bytes
package load_pkg;

  // ------------------------------------------------------------
  // data path widths
  // ------------------------------------------------------------
  // architectural word
  localparam int unsigned XLEN       = 64;
  localparam int unsigned XLEN_BYTES = XLEN / 8;
  // byte offset inside one word
  localparam int unsigned ALIGN_W    = 3;

  // request address, split into cache index and tag
  localparam int unsigned ADDR_W     = 32;
  localparam int unsigned INDEX_W    = 12;
  localparam int unsigned TAG_W      = ADDR_W - INDEX_W;
  // compared against pending stores
  localparam int unsigned PAGE_OFF_W = 12;

  // scoreboard id carried with every load
  localparam int unsigned TRANS_ID_W = 3;

  // outstanding load table
  localparam int unsigned NR_LDBUF   = 2;
  localparam int unsigned LDBUF_ID_W = 1;

  // ------------------------------------------------------------
  // load operations
  // ------------------------------------------------------------
  localparam int unsigned OP_W = 3;

  localparam logic [OP_W-1:0] OP_LD  = 3'd0;
  localparam logic [OP_W-1:0] OP_LW  = 3'd1;
  localparam logic [OP_W-1:0] OP_LWU = 3'd2;
  localparam logic [OP_W-1:0] OP_LH  = 3'd3;
  localparam logic [OP_W-1:0] OP_LHU = 3'd4;
  localparam logic [OP_W-1:0] OP_LB  = 3'd5;
  localparam logic [OP_W-1:0] OP_LBU = 3'd6;

  // transfer size as log2 of the byte count
  localparam int unsigned SIZE_W = 2;

  // ------------------------------------------------------------
  // request FSM states
  // ------------------------------------------------------------
  localparam int unsigned ST_W = 3;

  localparam logic [ST_W-1:0] ST_IDLE             = 3'd0;
  localparam logic [ST_W-1:0] ST_WAIT_GNT         = 3'd1;
  localparam logic [ST_W-1:0] ST_SEND_TAG         = 3'd2;
  localparam logic [ST_W-1:0] ST_WAIT_PAGE_OFFSET = 3'd3;
  localparam logic [ST_W-1:0] ST_WAIT_FLUSH       = 3'd4;

  // ------------------------------------------------------------
  // response word
  // ------------------------------------------------------------
  // same 64 bits, either as one word or as eight bytes
  typedef union packed {
    logic [XLEN-1:0]            word;
    logic [XLEN_BYTES-1:0][7:0] bytes;
  } rdata_u;

endpackage

// ==== src/load_result_align.sv ====
// realigns a cache response word and sign or zero extends the loaded field
`timescale 1ns/1ps

module load_result_align import load_pkg::*; (
  input  logic                  drvalid_i,
  input  logic [XLEN-1:0]       drdata_i,
  ldbuf_if.align                lb,
  output logic                  valid_o,
  output logic [TRANS_ID_W-1:0] trans_id_o,
  output logic [XLEN-1:0]       result_o
);

  rdata_u             rdata;
  logic [XLEN-1:0]    shifted;
  logic [ALIGN_W-1:0] sign_byte;
  logic               is_signed;
  logic               sign_bit;

  assign rdata.word = drdata_i;

  // ------------------------------------------------------------
  // realign
  // ------------------------------------------------------------
  // byte offset times eight
  assign shifted = rdata.word >> {lb.roffset, 3'b000};

  // ------------------------------------------------------------
  // sign bit
  // ------------------------------------------------------------
  assign is_signed = (lb.rop == OP_LW) || (lb.rop == OP_LH) || (lb.rop == OP_LB);

  // top byte of the field, picked from the unshifted word
  always_comb begin
    case (lb.rop)
      OP_LW, OP_LWU: sign_byte = lb.roffset + ALIGN_W'(3);
      OP_LH, OP_LHU: sign_byte = lb.roffset + ALIGN_W'(1);
      default:       sign_byte = lb.roffset;
    endcase
  end

  // unsigned loads pull the fill to zero
  assign sign_bit = is_signed && rdata.bytes[sign_byte][7];

  // ------------------------------------------------------------
  // result mux
  // ------------------------------------------------------------
  always_comb begin
    case (lb.rop)
      OP_LW, OP_LWU: result_o = {{(XLEN - 32){sign_bit}}, shifted[31:0]};
      OP_LH, OP_LHU: result_o = {{(XLEN - 16){sign_bit}}, shifted[15:0]};
      OP_LB, OP_LBU: result_o = {{(XLEN - 8){sign_bit}}, shifted[7:0]};
      // full word load
      default:       result_o = shifted;
    endcase
  end

  // killed or flushed entries never reach the scoreboard
  assign valid_o    = drvalid_i && lb.rd_valid;
  assign trans_id_o = lb.rtrans_id;

endmodule

// ==== src/load_unit_top.sv ====
// load unit top level with plain issue and cache ports
// request FSM, outstanding load table and result aligner
`timescale 1ns/1ps

module load_unit_top import load_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  flush_i,
  // issue queue
  input  logic                  valid_i,
  input  logic [ADDR_W-1:0]     vaddr_i,
  input  logic [OP_W-1:0]       op_i,
  input  logic [XLEN_BYTES-1:0] be_i,
  input  logic [TRANS_ID_W-1:0] trans_id_i,
  output logic                  pop_ld_o,
  // store address check
  output logic [PAGE_OFF_W-1:0] page_offset_o,
  input  logic                  page_offset_matches_i,
  // data cache request
  output logic                  dreq_o,
  output logic [INDEX_W-1:0]    dindex_o,
  output logic [TAG_W-1:0]      dtag_o,
  output logic                  dtag_valid_o,
  output logic                  dkill_o,
  output logic [XLEN_BYTES-1:0] dbe_o,
  output logic [SIZE_W-1:0]     dsize_o,
  output logic [LDBUF_ID_W-1:0] did_o,
  input  logic                  dgnt_i,
  // data cache response
  input  logic                  drvalid_i,
  input  logic [LDBUF_ID_W-1:0] drid_i,
  input  logic [XLEN-1:0]       drdata_i,
  // writeback
  output logic                  valid_o,
  output logic [TRANS_ID_W-1:0] trans_id_o,
  output logic [XLEN-1:0]       result_o
);

  ldbuf_if lb ();

  // low address bits go straight out, no translation here
  assign page_offset_o = vaddr_i[PAGE_OFF_W-1:0];
  assign dindex_o      = vaddr_i[INDEX_W-1:0];
  // request id is the slot the grant will fill
  assign did_o         = lb.windex;

  load_ctrl u_ctrl (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .flush_i               (flush_i),
    .valid_i               (valid_i),
    .vaddr_i               (vaddr_i),
    .op_i                  (op_i),
    .be_i                  (be_i),
    .trans_id_i            (trans_id_i),
    .page_offset_matches_i (page_offset_matches_i),
    .dgnt_i                (dgnt_i),
    .lb                    (lb.ctrl),
    .pop_ld_o              (pop_ld_o),
    .dreq_o                (dreq_o),
    .dtag_o                (dtag_o),
    .dtag_valid_o          (dtag_valid_o),
    .dkill_o               (dkill_o),
    .dbe_o                 (dbe_o),
    .dsize_o               (dsize_o)
  );

  load_buffer u_buffer (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .flush_i   (flush_i),
    .drvalid_i (drvalid_i),
    .drid_i    (drid_i),
    .lb        (lb.buffer)
  );

  load_result_align u_align (
    .drvalid_i  (drvalid_i),
    .drdata_i   (drdata_i),
    .lb         (lb.align),
    .valid_o    (valid_o),
    .trans_id_o (trans_id_o),
    .result_o   (result_o)
  );

endmodule

// ==== tb/load_model.svh ====
// data cache responder with random grant delay and per slot latency
// memory fill pattern and reference load results
`ifndef LOAD_MODEL_SVH
`define LOAD_MODEL_SVH

// responder state per request id
logic               slot_busy   [NR_LDBUF];
logic               slot_tagged [NR_LDBUF];
int unsigned        slot_lat    [NR_LDBUF];
logic [INDEX_W-1:0] slot_index  [NR_LDBUF];
logic [TAG_W-1:0]   slot_tag    [NR_LDBUF];
int unsigned        gnt_wait;
int unsigned        resp_rr;
int                 outstanding;
// blocks all responses while set
logic               hold_resp;

// log2 of the bytes a load moves
function automatic int unsigned field_log2(input logic [OP_W-1:0] op);
  case (op)
    OP_LD:         return 3;
    OP_LW, OP_LWU: return 2;
    OP_LH, OP_LHU: return 1;
    default:       return 0;
  endcase
endfunction

// word at an address, mixed from every word address bit
function automatic logic [XLEN-1:0] mem_word(input logic [TAG_W-1:0] tag,
                                             input logic [INDEX_W-1:0] index);
  logic [31:0] waddr;
  waddr = {3'b000, tag, index[INDEX_W-1:ALIGN_W]};
  return {waddr * 32'h9e3779b1, (waddr ^ 32'h5bd1e995) * 32'h85ebca6b};
endfunction

// field at the byte offset, then sign or zero fill
function automatic logic [XLEN-1:0] expected_result(input logic [OP_W-1:0] op,
                                                    input logic [ALIGN_W-1:0] off,
                                                    input logic [XLEN-1:0] word);
  int unsigned     bits;
  logic [XLEN-1:0] field;
  logic [XLEN-1:0] mask;
  bits  = 8 << field_log2(op);
  field = word >> (8 * off);
  mask  = (bits == XLEN) ? '1 : ((64'd1 << bits) - 64'd1);
  field = field & mask;
  // signed loads copy the top bit of the field upwards
  if ((op == OP_LW || op == OP_LH || op == OP_LB) && field[bits-1]) begin
    field = field | ~mask;
  end
  return field;
endfunction

task automatic cache_reset();
  for (int i = 0; i < NR_LDBUF; i++) begin
    slot_busy[i]   = 1'b0;
    slot_tagged[i] = 1'b0;
    slot_lat[i]    = 0;
  end
  gnt_wait    = 0;
  resp_rr     = 0;
  outstanding = 0;
  hold_resp   = 1'b0;
endtask

// ----------------------------------------------------------
// rising edge: tag capture, retire, grant
// ----------------------------------------------------------
task automatic cache_update();
  for (int i = 0; i < NR_LDBUF; i++) begin
    // the one slot still missing its tag takes it now
    if (slot_busy[i] && !slot_tagged[i] && dtag_valid_o && !dkill_o) begin
      slot_tag[i]    = dtag_o;
      slot_tagged[i] = 1'b1;
      slot_lat[i]    = 1 + $urandom % 8;
    end else if (slot_tagged[i] && slot_lat[i] != 0) begin
      slot_lat[i]--;
    end
  end
  if (drvalid_i) begin
    slot_busy[drid_i] = 1'b0;
    outstanding--;
  end
  if (dreq_o && dgnt_i) begin
    slot_busy[did_o]   = 1'b1;
    slot_tagged[did_o] = 1'b0;
    slot_index[did_o]  = dindex_o;
    outstanding++;
    gnt_wait = $urandom % 4;
  end else if (dreq_o && gnt_wait != 0) begin
    gnt_wait--;
  end
  resp_rr++;
endtask

// falling edge: grant level and at most one response
task automatic cache_drive();
  int unsigned i;
  logic        found;
  found     = 1'b0;
  dgnt_i    = (gnt_wait == 0);
  drvalid_i = 1'b0;
  drid_i    = '0;
  drdata_i  = '0;
  for (int k = 0; k < NR_LDBUF; k++) begin
    // rotating start so ready slots alternate
    i = (resp_rr + k) % NR_LDBUF;
    if (!hold_resp && !found && slot_busy[i] && slot_tagged[i] && slot_lat[i] == 0) begin
      found     = 1'b1;
      drvalid_i = 1'b1;
      drid_i    = LDBUF_ID_W'(i);
      drdata_i  = mem_word(slot_tag[i], slot_index[i]);
    end
  end
endtask

`endif

// ==== tb/tb_load_unit.sv ====
// load unit testbench with clock, reset, directed and random loads
// checks against the cache model, watchdog and summary
`timescale 1ns/1ps

module tb_load_unit import load_pkg::*; ();

  localparam int CLK_PERIOD = 4;
  localparam int N_RAND     = 20;
  // 29 op and offset pairs, random loads, then stall, full and flush loads
  localparam int N_LOADS         = 29 + N_RAND + 1 + 3 + 4;
  localparam int WATCHDOG_CYCLES = N_LOADS * 40 + 200;

  logic                  clk_i = 1'b0;
  logic                  rst_ni;
  logic                  flush_i;
  logic                  valid_i;
  logic [ADDR_W-1:0]     vaddr_i;
  logic [OP_W-1:0]       op_i;
  logic [XLEN_BYTES-1:0] be_i;
  logic [TRANS_ID_W-1:0] trans_id_i;
  logic                  pop_ld_o;
  logic [PAGE_OFF_W-1:0] page_offset_o;
  logic                  page_offset_matches_i;
  logic                  dreq_o;
  logic [INDEX_W-1:0]    dindex_o;
  logic [TAG_W-1:0]      dtag_o;
  logic                  dtag_valid_o;
  logic                  dkill_o;
  logic [XLEN_BYTES-1:0] dbe_o;
  logic [SIZE_W-1:0]     dsize_o;
  logic [LDBUF_ID_W-1:0] did_o;
  logic                  dgnt_i;
  logic                  drvalid_i;
  logic [LDBUF_ID_W-1:0] drid_i;
  logic [XLEN-1:0]       drdata_i;
  logic                  valid_o;
  logic [TRANS_ID_W-1:0] trans_id_o;
  logic [XLEN-1:0]       result_o;

  // what each request id should return
  logic [ADDR_W-1:0]     exp_addr    [NR_LDBUF];
  logic [OP_W-1:0]       exp_op      [NR_LDBUF];
  logic [TRANS_ID_W-1:0] exp_tid     [NR_LDBUF];
  logic                  exp_flushed [NR_LDBUF];
  logic [XLEN-1:0]       exp_res;
  logic                  tag_due;
  logic [LDBUF_ID_W-1:0] tag_id;
  logic                  kill_due;
  int                    errors;
  int                    checks;
  int                    results;
  int                    dropped;
  int unsigned           rng_seed;

  `include "load_model.svh"

  load_unit_top dut0 (.*);

  initial begin
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  task automatic check_true(input logic ok, input string what);
    checks++;
    assert (ok) else begin
      $display("Fail %0t: %s", $time, what);
      errors++;
    end
  endtask

  // free in the responder and no lower slot free
  function automatic logic is_lowest_free(input logic [LDBUF_ID_W-1:0] id);
    logic ok;
    ok = !slot_busy[id];
    for (int i = 0; i < NR_LDBUF; i++) begin
      if (i < id && !slot_busy[i]) begin
        ok = 1'b0;
      end
    end
    return ok;
  endfunction

  // ----------------------------------------------------------
  // issue side
  // ----------------------------------------------------------
  task automatic drive_load(input logic [OP_W-1:0] op, input logic [ADDR_W-1:0] addr,
                            input logic [TRANS_ID_W-1:0] tid);
    valid_i    = 1'b1;
    vaddr_i    = addr;
    op_i       = op;
    trans_id_i = tid;
    be_i = XLEN_BYTES'(((1 << (1 << field_log2(op))) - 1) << addr[ALIGN_W-1:0]);
  endtask

  // pop is seen at the rising edge and the queue head moves on afterwards
  task automatic wait_pop();
    @(posedge clk_i);
    while (!pop_ld_o) @(posedge clk_i);
    @(negedge clk_i);
    valid_i = 1'b0;
  endtask

  task automatic issue_load(input logic [OP_W-1:0] op, input logic [ADDR_W-1:0] addr,
                            input logic [TRANS_ID_W-1:0] tid);
    drive_load(op, addr, tid);
    wait_pop();
  endtask

  task automatic random_load(input logic [OP_W-1:0] op, input int unsigned off,
                             input int tid);
    logic [ADDR_W-1:0] addr;
    addr = $urandom;
    addr[ALIGN_W-1:0] = ALIGN_W'(off);
    issue_load(op, addr, TRANS_ID_W'(tid));
    repeat ($urandom % 3) @(negedge clk_i);
  endtask

  task automatic wait_drain();
    @(negedge clk_i);
    while (outstanding != 0) @(negedge clk_i);
  endtask

  // changed at the rising edge and seen by the responder at the next falling one
  task automatic set_hold(input logic hold);
    @(posedge clk_i);
    hold_resp = hold;
    @(negedge clk_i);
  endtask

  task automatic report_test(input string name, input int start_err);
    if (errors == start_err) $display("%s: done, no errors", name);
    else $display("%s: done, %0d errors", name, errors - start_err);
  endtask

  // ----------------------------------------------------------
  // output monitor sampled before the edge updates
  // ----------------------------------------------------------
  always @(posedge clk_i) begin
    if (rst_ni) begin
      check_true(!pop_ld_o || (dreq_o && dgnt_i), "pop_ld_o without request and grant");
      check_true(dkill_o == kill_due, "dkill_o does not follow the flush");
      if (kill_due) check_true(dtag_valid_o, "dtag_valid_o low in the kill cycle");
      kill_due = flush_i;
      if (tag_due) begin
        check_true(dtag_valid_o && dtag_o == exp_addr[tag_id][ADDR_W-1:INDEX_W],
                   $sformatf("tag %h valid %b, expected %h", dtag_o, dtag_valid_o,
                             exp_addr[tag_id][ADDR_W-1:INDEX_W]));
      end
      if (drvalid_i && exp_flushed[drid_i]) begin
        check_true(!valid_o, "valid_o for a flushed load");
        dropped++;
      end else if (drvalid_i) begin
        exp_res = expected_result(exp_op[drid_i], exp_addr[drid_i][ALIGN_W-1:0],
                                  mem_word(exp_addr[drid_i][ADDR_W-1:INDEX_W],
                                           exp_addr[drid_i][INDEX_W-1:0]));
        check_true(valid_o && trans_id_o == exp_tid[drid_i] && result_o == exp_res,
                   $sformatf("id %0d: valid %b trans_id %0d result %h, expected %0d %h",
                             drid_i, valid_o, trans_id_o, result_o, exp_tid[drid_i], exp_res));
        results++;
      end else begin
        check_true(!valid_o, "valid_o without a cache response")
        ;
      end
      if (flush_i) begin
        for (int i = 0; i < NR_LDBUF; i++) exp_flushed[i] = 1'b1;
      end
      tag_due = dreq_o && dgnt_i;
      if (dreq_o && dgnt_i) begin
        // low address bits, size and byte enables of the granted request
        check_true(dindex_o == vaddr_i[INDEX_W-1:0] &&
                   page_offset_o == vaddr_i[PAGE_OFF_W-1:0],
                   $sformatf("index %h page offset %h for address %h",
                             dindex_o, page_offset_o, vaddr_i));
        check_true(dsize_o == SIZE_W'(field_log2(op_i)) && dbe_o == be_i,
                   $sformatf("size %0d be %h, expected %0d %h",
                             dsize_o, dbe_o, field_log2(op_i), be_i));
        // slot numbering follows the lowest free slot
        check_true(is_lowest_free(did_o),
                   $sformatf("request id %0d is not the lowest free slot", did_o));
        exp_addr[did_o]    = vaddr_i;
        exp_op[did_o]      = op_i;
        exp_tid[did_o]     = trans_id_i;
        exp_flushed[did_o] = 1'b0;
        tag_id             = did_o;
      end
      cache_update();
    end
  end

  always @(negedge clk_i) begin
    cache_drive();
  end

  // ----------------------------------------------------------
  // tests
  // ----------------------------------------------------------
  task automatic op_sweep();
    int              start_err;
    logic [OP_W-1:0] op;
    start_err = errors;
    // every operation at every aligned offset
    for (int o = 0; o < 7; o++) begin
      for (int off = 0; off < XLEN_BYTES; off += (1 << field_log2(OP_W'(o)))) begin
        random_load(OP_W'(o), off, o + off);
      end
    end
    for (int n = 0; n < N_RAND; n++) begin
      op = OP_W'($urandom % 7);
      random_load(op, ($urandom % XLEN_BYTES) & ~((1 << field_log2(op)) - 1), n);
    end
    wait_drain();
    report_test("op sweep and random loads", start_err);
  endtask

  task automatic offset_stall();
    int start_err;
    start_err = errors;
    page_offset_matches_i = 1'b1;
    drive_load(OP_LH, 32'h0001_2346, 3'd5);
    repeat (6) begin
      @(posedge clk_i);
      check_true(!dreq_o && !pop_ld_o, "request made while the page offset matches");
    end
    @(negedge clk_i);
    page_offset_matches_i = 1'b0;
    wait_pop();
    wait_drain();
    report_test("page offset stall", start_err);
  endtask

  task automatic full_buffer();
    int start_err;
    start_err = errors;
    set_hold(1'b1);
    issue_load(OP_LD, 32'h0000_1000, 3'd1);
    issue_load(OP_LW, 32'h0000_2004, 3'd2);
    // third load waits for a free slot
    drive_load(OP_LBU, 32'h0000_3007, 3'd3);
    repeat (6) begin
      @(posedge clk_i);
      check_true(!dreq_o && !pop_ld_o, "request made with a full load buffer");
    end
    set_hold(1'b0);
    wait_pop();
    wait_drain();
    report_test("full buffer", start_err);
  endtask

  task automatic flush_sequence();
    int start_err;
    start_err = errors;
    set_hold(1'b1);
    issue_load(OP_LWU, 32'h0000_4000, 3'd6);
    issue_load(OP_LB, 32'h0000_5003, 3'd7);
    // tag cycle of the second load goes by first
    @(negedge clk_i);
    flush_i = 1'b1;
    @(negedge clk_i);
    flush_i = 1'b0;
    set_hold(1'b0);
    wait_drain();
    check_true(dropped == 2, "flushed loads were not both answered");
    issue_load(OP_LHU, 32'h0000_6002, 3'd0);
    issue_load(OP_LD, 32'h0000_7008, 3'd1);
    wait_drain();
    report_test("flush", start_err);
  endtask

  initial begin
    rng_seed = 32'h8abc;
    rng_seed = $urandom(rng_seed);
    rst_ni                = 1'b0;
    flush_i               = 1'b0;
    valid_i               = 1'b0;
    vaddr_i               = '0;
    op_i                  = '0;
    be_i                  = '0;
    trans_id_i            = '0;
    page_offset_matches_i = 1'b0;
    dgnt_i                = 1'b0;
    drvalid_i             = 1'b0;
    drid_i                = '0;
    drdata_i              = '0;
    errors   = 0;
    checks   = 0;
    results  = 0;
    dropped  = 0;
    tag_due  = 1'b0;
    tag_id   = '0;
    kill_due = 1'b0;
    cache_reset();
    repeat (2) @(negedge clk_i);
    rst_ni = 1'b1;
    op_sweep();
    offset_stall();
    full_buffer();
    flush_sequence();
    $display("checks %0d, results %0d, flushed responses %0d, errors %0d",
             checks, results, dropped, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  // bound on the whole run of about 40 cycles per load
  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("timeout: the run did not complete within %0d cycles", WATCHDOG_CYCLES);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule
